// File: hdl/bht_pkg.sv
// Geometry and counter encoding of the branch history table
// Everything here describes the table itself, not the messages that reach it
package bht_pkg;

    // Index width of the table
    // Ten bits gives 1024 counters, enough for a small in-order core
    localparam int BHT_ABITS = 10;

    // Number of counters held in the table
    localparam int BHT_ENTRIES = 1 << BHT_ABITS;

    // One 2-bit saturating counter per entry
    typedef logic [1:0] counter_t;

    // Table index as formed by the fetch stage
    typedef logic [BHT_ABITS-1:0] index_t;

    // Counter states in increasing order of taken confidence
    // The upper bit alone is the taken prediction
    localparam counter_t CNT_STRONG_NT = 2'd0;
    localparam counter_t CNT_WEAK_NT   = 2'd1;
    localparam counter_t CNT_WEAK_T    = 2'd2;
    localparam counter_t CNT_STRONG_T  = 2'd3;

    // Value the sweeper writes into every entry after reset
    // Weakly not taken lets one taken branch flip the prediction
    localparam counter_t CNT_INIT = CNT_WEAK_NT;

endpackage

// File: hdl/bpu_msg_pkg.sv
// Records that travel between the pipeline stages and the table
// The index type comes from the table geometry package
package bpu_msg_pkg;

    // Lookup from the fetch stage
    // Only the already hashed index is carried
    typedef struct packed {
        bht_pkg::index_t index;
    } lookup_req_t;

    // Resolved branch from the execute stage
    // This is also the payload stored in the update queue
    typedef struct packed {
        // Entry to be trained
        bht_pkg::index_t index;
        // Set when the branch was taken, which counts the entry up
        logic            taken;
    } update_req_t;

endpackage

// File: hdl/bht_ram.sv
`timescale 1ns/1ns

// Counter storage with two ports
// Port 0 reads or writes and serves the sweeper and the update path
// Port 1 only reads and serves the fetch stage lookup
module bht_ram (
    input  logic              clk,
    // Read/write port
    input  bht_pkg::index_t   addr0,
    input  logic              re0,
    output bht_pkg::counter_t rd0,
    input  bht_pkg::counter_t wr0,
    input  logic              we0,
    // Read-only port
    input  bht_pkg::index_t   addr1,
    input  logic              re1,
    output bht_pkg::counter_t rd1
);

    // The counter array itself
    // Its contents are defined by the sweeper, so it has no reset
    bht_pkg::counter_t mem [bht_pkg::BHT_ENTRIES];

    // Port 0 registers the addressed counter on a read
    // The write shares the same address and lands at the same edge
    always_ff @(posedge clk) begin
        if (re0) begin
            rd0 <= mem[addr0];
        end
        if (we0) begin
            mem[addr0] <= wr0;
        end
    end

    // Port 1 registers its counter and holds it while re1 is low
    // A write to the same entry in the same cycle is not seen yet,
    // the old value is returned
    always_ff @(posedge clk) begin
        if (re1) begin
            rd1 <= mem[addr1];
        end
    end

    // Port 0 is a single port, so the table must never read and write it
    // in one cycle
    // The read and the write phases of a retire come from the table's
    // phase register and the sweeper, both outside this module
    assert property (@(posedge clk) !(re0 && we0))
        else $error("bht_ram: read and write on port 0 in the same cycle");

endmodule

// File: hdl/update_fifo.sv
`timescale 1ns/1ns

// Queue of resolved-branch updates waiting to be retired
// The head is presented without a pop, so the table can read the
// counter first and pop only when it writes the result back
module update_fifo #(
    parameter int DEPTH_BITS = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    // Write side
    input  bpu_msg_pkg::update_req_t in_data,
    input  logic                     in_valid,
    output logic                     full,
    // Read side
    output bpu_msg_pkg::update_req_t out_data,
    output logic                     out_valid,
    input  logic                     pop
);

    localparam int DEPTH = 1 << DEPTH_BITS;

    // Payload storage needs no reset, the count says what is valid
    bpu_msg_pkg::update_req_t mem [DEPTH];

    logic [DEPTH_BITS-1:0] wr_ptr;
    logic [DEPTH_BITS-1:0] rd_ptr;
    // One bit wider than the pointers so a full queue can be told from an empty one
    logic [DEPTH_BITS:0]   count;
    logic                  push;

    // Full is taken from the count before any pop in this cycle
    // A strobe that meets a pop is only dropped if the queue was already full
    assign full      = (count == (DEPTH_BITS + 1)'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    // A strobe into a full queue is ignored here
    // The table reports it as a drop
    assign push = in_valid && !full;

    // Storage write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The consumer may only pop an entry it has seen at the head
    assert property (@(posedge clk) disable iff (reset) pop |-> out_valid)
        else $error("update_fifo: pop while empty");

    // The count can never pass the depth, even over many cycles of strobes
    assert property (@(posedge clk) disable iff (reset) count <= (DEPTH_BITS + 1)'(DEPTH))
        else $error("update_fifo: occupancy above depth");

endmodule

// File: hdl/bht_init.sv
`timescale 1ns/1ns

// Reset-time sweeper
// Walks through every table index once, one per cycle, so that the table
// can write the initial counter value into each entry
module bht_init (
    input  logic            clk,
    input  logic            reset,
    output logic            init_active,
    output bht_pkg::index_t init_index
);

    localparam bht_pkg::index_t LAST_INDEX = bht_pkg::index_t'(bht_pkg::BHT_ENTRIES - 1);

    // Set once the sweep has finished and cleared only by the next reset
    logic init_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            init_active <= 1'b0;
            init_index  <= '0;
            init_done   <= 1'b0;
        end else if (!init_active && !init_done) begin
            // First cycle out of reset starts the sweep at index zero
            init_active <= 1'b1;
        end else if (init_active) begin
            if (init_index == LAST_INDEX) begin
                // Last entry written, the index stays where it is
                init_active <= 1'b0;
                init_done   <= 1'b1;
            end else begin
                init_index <= init_index + 1'b1;
            end
        end
    end

    // Once started the index only climbs, it never comes back to zero
    // while the sweep is still running
    assert property (@(posedge clk) disable iff (reset)
        (init_active && $past(init_active)) |-> (init_index != '0))
        else $error("bht_init: index wrapped during init");

endmodule

// File: hdl/bht_table.sv
`timescale 1ns/1ns

// Branch history table
// Serves one lookup per cycle on the RAM's read-only port and retires
// queued updates as a read-modify-write on the read/write port
// While the sweeper runs, the read/write port is handed to it
module bht_table #(
    parameter int UPD_DEPTH_BITS = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    // Fetch stage lookup
    input  logic                     lookup_valid,
    input  bpu_msg_pkg::lookup_req_t lookup,
    output bht_pkg::counter_t        counter,
    // Execute stage update
    input  logic                     update_valid,
    input  bpu_msg_pkg::update_req_t update,
    output logic                     update_dropped,
    // Sweeper
    input  logic                     init_active,
    input  bht_pkg::index_t          init_index
);

    // Queue side
    bpu_msg_pkg::update_req_t upd_head;
    logic                     upd_head_valid;
    logic                     upd_full;
    logic                     upd_pop;

    // Read/write port of the RAM
    bht_pkg::index_t   ram_addr0;
    logic              ram_re0;
    logic              ram_we0;
    bht_pkg::counter_t ram_rd0;
    bht_pkg::counter_t ram_wr0;

    // Retire phase
    // Low is the read cycle of an update, high is its write cycle
    logic write_phase;

    // Counter after the update is applied
    bht_pkg::counter_t cnt_inc;
    bht_pkg::counter_t cnt_dec;
    bht_pkg::counter_t cnt_next;

    update_fifo #(
        .DEPTH_BITS(UPD_DEPTH_BITS)
    ) upd_fifo_i (
        .clk      (clk),
        .reset    (reset),
        .in_data  (update),
        .in_valid (update_valid),
        .full     (upd_full),
        .out_data (upd_head),
        .out_valid(upd_head_valid),
        .pop      (upd_pop)
    );

    // A strobe is lost when the queue was full at the start of the cycle
    assign update_dropped = update_valid && upd_full;

    // The head stays in place during its read cycle and is popped only
    // when the new counter is written
    always_ff @(posedge clk) begin
        if (reset) begin
            write_phase <= 1'b0;
        end else if (write_phase) begin
            write_phase <= 1'b0;
        end else begin
            write_phase <= upd_head_valid && !init_active;
        end
    end

    assign upd_pop = write_phase;

    // Saturating step at both ends of the counter range
    assign cnt_inc  = (ram_rd0 == bht_pkg::CNT_STRONG_T) ? ram_rd0 : ram_rd0 + 2'd1;
    assign cnt_dec  = (ram_rd0 == bht_pkg::CNT_STRONG_NT) ? ram_rd0 : ram_rd0 - 2'd1;
    assign cnt_next = upd_head.taken ? cnt_inc : cnt_dec;

    // The sweeper owns port 0 while it runs, the queue is held meanwhile
    assign ram_addr0 = init_active ? init_index : upd_head.index;
    assign ram_re0   = upd_head_valid && !write_phase && !init_active;
    assign ram_we0   = init_active || write_phase;
    assign ram_wr0   = init_active ? bht_pkg::CNT_INIT : cnt_next;

    bht_ram ram_i (
        .clk  (clk),
        .addr0(ram_addr0),
        .re0  (ram_re0),
        .rd0  (ram_rd0),
        .wr0  (ram_wr0),
        .we0  (ram_we0),
        .addr1(lookup.index),
        .re1  (lookup_valid),
        .rd1  (counter)
    );

    // Nothing is retired while the sweeper writes, otherwise an update
    // could be overwritten by the initial value
    assert property (@(posedge clk) disable iff (reset) init_active |-> !upd_pop)
        else $error("bht_table: update retired during init");

endmodule

// File: hdl/bpu_top.sv
`timescale 1ns/1ns

// Branch predictor history table subsystem
// The sweeper runs once after reset and the table serves lookups and
// updates from the pipeline
module bpu_top #(
    parameter int UPD_DEPTH_BITS = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    // Fetch stage lookup, counter follows one cycle later
    input  logic                     lookup_valid,
    input  bpu_msg_pkg::lookup_req_t lookup,
    output bht_pkg::counter_t        counter,
    // Execute stage update
    input  logic                     update_valid,
    input  bpu_msg_pkg::update_req_t update,
    output logic                     update_dropped,
    // High while the table is being initialised
    output logic                     init_busy
);

    // Sweeper to table
    logic            init_active;
    bht_pkg::index_t init_index;

    bht_init init_i (
        .clk        (clk),
        .reset      (reset),
        .init_active(init_active),
        .init_index (init_index)
    );

    bht_table #(
        .UPD_DEPTH_BITS(UPD_DEPTH_BITS)
    ) table_i (
        .clk           (clk),
        .reset         (reset),
        .lookup_valid  (lookup_valid),
        .lookup        (lookup),
        .counter       (counter),
        .update_valid  (update_valid),
        .update        (update),
        .update_dropped(update_dropped),
        .init_active   (init_active),
        .init_index    (init_index)
    );

    // Busy is reported for exactly the sweep
    assign init_busy = init_active;

endmodule

// File: bench/tb_bpu.sv
`timescale 1ns/1ns

module tb_bpu;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int MARGIN       = 200;

    logic                     clk;
    logic                     reset;
    logic                     lookup_valid;
    bpu_msg_pkg::lookup_req_t lookup;
    bht_pkg::counter_t        counter;
    logic                     update_valid;
    bpu_msg_pkg::update_req_t update;
    logic                     update_dropped;
    logic                     init_busy;

    // Steps as read from the cases file
    // One entry per line
    string step_kind[$];
    string step_name[$];
    int    step_a[$];
    int    step_b[$];

    int          budget;
    int unsigned rand_state;
    int          total_errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    string       test_name;
    // Lookup waiting for its counter in the next cycle
    logic              pending;
    bht_pkg::counter_t pending_exp;
    logic              dropped_seen;
    logic              expect_drop;

    bpu_top #(
        .UPD_DEPTH_BITS(2)
    ) dut_i (
        .clk           (clk),
        .reset         (reset),
        .lookup_valid  (lookup_valid),
        .lookup        (lookup),
        .counter       (counter),
        .update_valid  (update_valid),
        .update        (update),
        .update_dropped(update_dropped),
        .init_busy     (init_busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Plain LCG
    // The upper half of the state is the most random part
    function int unsigned next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state >> 16;
    endfunction

    task automatic compare_counter(string name, bht_pkg::counter_t got, bht_pkg::counter_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            total_errors++;
            test_errors++;
        end
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0b expected %0b", $time, name, got, exp);
            total_errors++;
            test_errors++;
        end
    endtask

    // One clock cycle of the bench
    // The drop pulse is combinational, so it is caught at the falling edge of the
    // cycle it belongs to
    // The registered counter is checked 1 ns after the edge
    task automatic tick();
        @(negedge clk);
        if (update_dropped) dropped_seen = 1'b1;
        @(posedge clk);
        #1;
        if (pending) compare_counter("counter", counter, pending_exp);
        pending      = 1'b0;
        lookup_valid = 1'b0;
        update_valid = 1'b0;
    endtask

    task automatic read_cases();
        int    fd;
        int    n;
        int    a;
        int    b;
        int    sum_w;
        int    n_upd;
        string line;
        string kind;
        string name;
        sum_w = 0;
        n_upd = 0;
        fd = $fopen("bench/bpu_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the cases file bench/bpu_cases.txt");
            total_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = "";
                name = "";
                a = 0;
                b = 0;
                n = $sscanf(line, "%s", kind);
                if (n < 1 || kind.substr(0, 0) == "#") continue;
                if (kind == "T") n = $sscanf(line, "%s %s", kind, name);
                else n = $sscanf(line, "%s %d %d", kind, a, b);
                step_kind.push_back(kind);
                step_name.push_back(name);
                step_a.push_back(a);
                step_b.push_back(b);
                if (kind == "W") sum_w += a;
                if (kind == "U") n_upd += 1;
                if (kind == "B") n_upd += b;
            end
            $fclose(fd);
        end
        // Each update may also carry up to three random idle cycles
        budget = RESET_CYCLES + bht_pkg::BHT_ENTRIES + sum_w + 5 * n_upd
               + 2 * step_kind.size() + MARGIN;
    endtask

    task automatic run_step(int i);
        int gap;
        case (step_kind[i])
            "T": begin
                test_name    = step_name[i];
                test_errors  = 0;
                dropped_seen = 1'b0;
                expect_drop  = 1'b0;
                tests_run++;
            end
            "U": begin
                tick();
                update_valid = 1'b1;
                update.index = bht_pkg::index_t'(step_a[i]);
                update.taken = (step_b[i] != 0);
                // Random idle cycles only separate one update from the next
                // A lookup right after the last update meets it still retiring
                if (i + 1 < step_kind.size() && step_kind[i + 1] == "U") begin
                    gap = int'(next_random() % 4);
                    repeat (gap) tick();
                end
            end
            "L": begin
                tick();
                lookup_valid = 1'b1;
                lookup.index = bht_pkg::index_t'(step_a[i]);
                pending      = 1'b1;
                pending_exp  = bht_pkg::counter_t'(step_b[i]);
            end
            "W": repeat (step_a[i]) tick();
            "B": begin
                // Strobes in consecutive cycles overrun the four-entry queue
                expect_drop = 1'b1;
                for (int k = 0; k < step_b[i]; k++) begin
                    tick();
                    update_valid = 1'b1;
                    update.index = bht_pkg::index_t'(step_a[i] + k);
                    update.taken = 1'b1;
                end
            end
            "E": begin
                tick();
                compare_flag("update_dropped", dropped_seen, expect_drop);
                compare_flag("init_busy", init_busy, 1'b0);
                if (test_errors == 0) begin
                    $display("PASS %s", test_name);
                end else begin
                    tests_failed++;
                    $display("FAIL %s with %0d errors", test_name, test_errors);
                end
            end
            default: begin
                $display("Unknown step kind %s in the cases file", step_kind[i]);
                total_errors++;
            end
        endcase
    endtask

    initial begin
        logic rose;
        int   waited;
        reset        = 1'b1;
        lookup_valid = 1'b0;
        lookup       = '0;
        update_valid = 1'b0;
        update       = '0;
        pending      = 1'b0;
        pending_exp  = '0;
        dropped_seen = 1'b0;
        expect_drop  = 1'b0;
        rand_state   = 32'd22420;
        budget       = 0;
        total_errors = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        read_cases();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        compare_flag("init_busy", init_busy, 1'b0);
        reset = 1'b0;
        rose  = 1'b0;
        for (waited = 0; waited < 4 && !rose; waited++) begin
            @(posedge clk);
            #1;
            rose = init_busy;
        end
        if (!rose) begin
            $display("init_busy never rose after reset was released");
            total_errors++;
        end else begin
            // The sweep covers every entry at one per cycle
            waited = 1;
            while (init_busy && waited <= bht_pkg::BHT_ENTRIES + 8) begin
                @(posedge clk);
                #1;
                if (init_busy) waited++;
            end
            if (waited != bht_pkg::BHT_ENTRIES) begin
                $display("init_busy lasted %0d cycles instead of %0d", waited,
                         bht_pkg::BHT_ENTRIES);
                total_errors++;
            end
            for (int i = 0; i < step_kind.size(); i++) run_step(i);
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Budget is known once the cases file has been read
    initial begin
        wait (budget != 0);
        repeat (budget) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", budget);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: all.f
hdl/bht_pkg.sv
hdl/bpu_msg_pkg.sv
hdl/bht_ram.sv
hdl/update_fifo.sv
hdl/bht_init.sv
hdl/bht_table.sv
hdl/bpu_top.sv
bench/tb_bpu.sv

// File: Makefile
# Verilator build and run of the branch history table testbench

VERILATOR ?= verilator
TOP       ?= tb_bpu
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q 'All tests passed!' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/bpu_cases.txt
# Columns are a step kind and up to two decimal numbers
# T name, U index taken, L index expected, W idle cycles, B start length, E
T init_values
L 0 1
L 1023 1
L 1 1
L 512 1
L 77 1
E
T taken_saturate
U 5 1
W 8
L 5 2
U 5 1
U 5 1
U 5 1
W 14
L 5 3
E
T not_taken_and_mixed
U 9 0
U 9 0
W 8
L 9 0
U 9 0
W 6
L 9 0
U 9 1
U 9 1
U 9 0
U 9 1
U 9 1
U 9 1
W 16
L 9 3
E
T back_to_back
U 20 1
U 21 0
U 22 1
U 23 1
W 16
L 20 2
L 21 0
L 22 2
L 23 2
U 30 1
U 30 1
U 30 1
U 30 0
W 14
L 30 2
E
T burst_drop
B 100 10
W 30
L 100 2
L 101 2
L 102 2
L 103 2
E
T lookup_stream
U 200 1
U 201 1
U 202 0
L 0 1
L 1 1
L 2 1
L 3 1
L 4 1
L 5 3
L 9 3
L 1023 1
W 10
L 200 2
L 201 2
L 202 0
E
